// File: flist.f
design/cpu_bus_pkg.sv
design/cpu_isa_pkg.sv
design/fetch_unit.sv
design/sequencer.sv
design/accumulator_datapath.sv
design/data_port.sv
design/accum_cpu.sv
dv/tb_wb_memory.sv
dv/accum_cpu_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := accum_cpu_tb
FLIST      := flist.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "run failed"; exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/accum_cpu_tb.sv
`timescale 1ns/10ps

module accum_cpu_tb;

    import cpu_bus_pkg::*;
    import cpu_isa_pkg::*;

    localparam int          clk_period = 40;
    localparam addr_t       prog_base  = 16'h0010;
    localparam int          mem_depth  = 256;
    localparam int          n_runs     = 7;
    localparam int          max_instr  = 100;
    localparam int          max_cycles = 24;  // two fetches and a load with three waits each
    localparam int          run_cycles = mem_depth + 8 + max_instr * max_cycles;
    localparam logic [31:0] seed       = 32'h1657_8fd4;

    logic  clk;
    logic  rst_n;
    logic  i_cyc, i_stb, i_we, i_ack;
    addr_t i_adr;
    data_t i_dat_w, i_dat_r;
    logic  d_cyc, d_stb, d_we, d_ack;
    addr_t d_adr;
    data_t d_dat_w, d_dat_r;
    data_t acc;
    logic  halted;

    logic        zero_wait;
    logic        load_we;
    addr_t       load_adr;
    data_t       i_load_dat, d_load_dat;
    logic [31:0] bus_rng = seed;
    logic [31:0] data_rng;

    data_t prog [$];
    data_t init_mem [mem_depth];
    data_t m_mem [mem_depth];   // expected data memory
    data_t m_ac;
    data_t m_r [4];
    data_t load_vals [4];
    data_t loop_count;

    accum_cpu #(
        .reset_pc (prog_base)
    ) accum_cpu_inst (
        .clk, .rst_n,
        .i_cyc, .i_stb, .i_we, .i_adr, .i_dat_w, .i_dat_r, .i_ack,
        .d_cyc, .d_stb, .d_we, .d_adr, .d_dat_w, .d_dat_r, .d_ack,
        .acc, .halted
    );

    tb_wb_memory #(.depth(mem_depth)) imem_inst (
        .clk, .rst_n, .cyc(i_cyc), .stb(i_stb), .we(i_we), .adr(i_adr),
        .dat_w(i_dat_w), .dat_r(i_dat_r), .ack(i_ack), .wait_draw(bus_rng[1:0]),
        .zero_wait, .load_we, .load_adr, .load_dat(i_load_dat)
    );

    tb_wb_memory #(.depth(mem_depth)) dmem_inst (
        .clk, .rst_n, .cyc(d_cyc), .stb(d_stb), .we(d_we), .adr(d_adr),
        .dat_w(d_dat_w), .dat_r(d_dat_r), .ack(d_ack), .wait_draw(bus_rng[5:4]),
        .zero_wait, .load_we, .load_adr, .load_dat(d_load_dat)
    );

    always #(clk_period / 2) clk = ~clk;

    always @(posedge clk) bus_rng <= next_rand(bus_rng);

    function automatic logic [31:0] next_rand(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic data_t fill_word(input int a);
        logic [7:0] b;
        b = a[7:0];
        return {b ^ 8'h5a, ~b};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("SIMULATION FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check_word(input string name, input data_t expected, input data_t actual);
        if (actual !== expected)
        begin
            $display("error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            abort_run("result mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("error at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
            abort_run("flag mismatch");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // program assembly and the reference model
    ////////////////////////////////////////////////////////////////////////////

    task automatic begin_program();
        prog.delete();
        m_ac = 16'h0000;
        for (int i = 0; i < 4; i++)
            m_r[i] = 16'h0000;
        for (int a = 0; a < mem_depth; a++)
        begin
            init_mem[a] = fill_word(a);
            m_mem[a]    = fill_word(a);
        end
    endtask

    task automatic set_data(input addr_t a, input data_t v);
        init_mem[a] = v;
        m_mem[a]    = v;
    endtask

    // one instruction applied to the model with 16-bit wrap
    task automatic step(input logic [7:0] op, input data_t arg);
        reg_sel_t rs;
        rs = arg[1:0];
        case (op)
            ADD:     m_ac = m_ac + m_r[rs];
            SUB:     m_ac = m_ac - m_r[rs];
            MUL:     m_ac = m_ac * m_r[rs];
            SHR:     m_ac = m_ac >> 1;
            SHL:     m_ac = m_ac << 1;
            CLAC:    m_ac = 16'h0000;
            INCAC:   m_ac = m_ac + 16'd1;
            MVAC:    m_r[rs] = m_ac;
            MOVREG:  m_ac = m_r[rs];
            INCR:    m_r[rs] = m_r[rs] + 16'd1;
            LODAC:   m_ac = m_mem[arg[7:0]];
            STOAC:   m_mem[arg[7:0]] = m_ac;
            default: ;
        endcase
    endtask

    task automatic put1(input logic [7:0] op, input reg_sel_t rs);
        prog.push_back({op, 6'b0, rs});
    endtask

    task automatic put2(input logic [7:0] op, input data_t w);
        prog.push_back({op, 8'h00});
        prog.push_back(w);
    endtask

    task automatic ins1(input logic [7:0] op, input reg_sel_t rs);
        put1(op, rs);
        step(op, data_t'(rs));
    endtask

    task automatic ins2(input logic [7:0] op, input data_t w);
        put2(op, w);
        step(op, w);
    endtask

    function automatic data_t here();
        return prog_base + addr_t'(prog.size());
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // running a program
    ////////////////////////////////////////////////////////////////////////////

    // memories are written while the processor is held in reset
    task automatic load_program();
        int base;
        base = int'(prog_base);
        @(posedge clk);
        rst_n <= 1'b0;
        for (int a = 0; a < mem_depth; a++)
        begin
            @(posedge clk);
            load_we  <= 1'b1;
            load_adr <= addr_t'(a);
            if (a >= base && a < base + prog.size())
                i_load_dat <= prog[a - base];
            else
                i_load_dat <= {8'hFF, 8'(a)};  // a stray fetch halts
            d_load_dat <= init_mem[a];
        end
        @(posedge clk);
        load_we <= 1'b0;
        repeat (5) @(posedge clk);
    endtask

    task automatic start_and_wait();
        @(posedge clk);
        rst_n <= 1'b1;
        do
            @(negedge clk);
        while (!halted);
    endtask

    task automatic check_results();
        repeat (4) @(negedge clk);  // halted holds until the next reset
        check_flag("halted", 1'b1, halted);
        check_word("acc", m_ac, acc);
        for (int a = 0; a < mem_depth; a++)
            check_word($sformatf("dmem[%02h]", a), m_mem[a], dmem_inst.mem[a]);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset();
        begin_program();
        ins1(ENDOP, 2'd0);
        load_program();
        @(negedge clk);
        check_flag("halted", 1'b0, halted);
        check_flag("i_cyc", 1'b0, i_cyc);
        check_flag("i_stb", 1'b0, i_stb);
        check_flag("i_we", 1'b0, i_we);
        check_flag("d_cyc", 1'b0, d_cyc);
        check_flag("d_stb", 1'b0, d_stb);
        check_flag("d_we", 1'b0, d_we);
        check_word("acc", 16'h0000, acc);
        start_and_wait();
        check_results();
    endtask

    task automatic test_arithmetic();
        begin_program();
        ins1(CLAC, 2'd0);
        ins1(INCAC, 2'd0);
        ins1(INCAC, 2'd0);
        ins1(INCAC, 2'd0);
        ins1(MVAC, 2'd1);
        ins1(SHL, 2'd0);
        ins1(SHL, 2'd0);
        ins1(INCAC, 2'd0);
        ins1(MVAC, 2'd2);
        ins1(MUL, 2'd1);
        ins2(STOAC, 16'h0080);
        ins1(SUB, 2'd2);
        ins1(MVAC, 2'd3);
        ins1(INCR, 2'd3);
        ins1(NOP, 2'd0);
        ins1(MOVREG, 2'd3);
        ins1(ADD, 2'd1);
        ins1(SHR, 2'd0);
        ins2(STOAC, 16'h0081);
        ins1(8'h20, 2'd1);     // undefined opcode
        ins2(STOAC, 16'h0082);
        ins1(CLAC, 2'd0);
        ins1(SUB, 2'd1);       // wraps below zero
        ins2(STOAC, 16'h0083);
        ins1(MUL, 2'd2);
        ins1(SHL, 2'd0);
        ins2(STOAC, 16'h0084);
        ins1(INCR, 2'd0);
        ins1(MOVREG, 2'd0);
        ins1(ADD, 2'd3);
        ins2(STOAC, 16'h0085);
        ins1(ENDOP, 2'd0);
        load_program();
        start_and_wait();
        check_results();
    endtask

    task automatic test_loads();
        begin_program();
        for (int i = 0; i < 4; i++)
            set_data(addr_t'(16'h0040 + i), load_vals[i]);
        ins2(LODAC, 16'h0040);
        ins1(MVAC, 2'd1);
        ins2(LODAC, 16'h0041);
        ins1(ADD, 2'd1);
        ins2(STOAC, 16'h0090);
        ins1(MVAC, 2'd2);
        ins2(LODAC, 16'h0042);
        ins1(MUL, 2'd2);
        ins2(STOAC, 16'h0091);
        ins2(LODAC, 16'h0043);
        ins1(SUB, 2'd1);
        ins1(SHR, 2'd0);
        ins2(STOAC, 16'h0092);
        ins2(LODAC, 16'h0090);
        ins1(ADD, 2'd2);
        ins2(STOAC, 16'h0040);
        ins1(ENDOP, 2'd0);
        load_program();
        start_and_wait();
        check_results();
    endtask

    task automatic test_jumps();
        data_t loop_top;
        int    fix;
        begin_program();
        set_data(16'h0050, loop_count);
        ins1(CLAC, 2'd0);
        ins1(INCAC, 2'd0);
        ins1(MVAC, 2'd1);
        ins2(LODAC, 16'h0050);
        loop_top = here();     // countdown loop with one store and one INCR per pass
        put2(STOAC, 16'h0060);
        put1(INCR, 2'd2);
        put1(SUB, 2'd1);
        put2(JMPNZ, loop_top);
        put1(MOVREG, 2'd2);
        put2(STOAC, 16'h0061);
        fix = prog.size() + 1;
        put2(JUMP, 16'h0000);
        put2(STOAC, 16'h0062);
        prog[fix] = here();
        put1(CLAC, 2'd0);
        fix = prog.size() + 1;
        put2(JMPZ, 16'h0000);  // taken
        put2(STOAC, 16'h0063);
        prog[fix] = here();
        put1(INCAC, 2'd0);
        fix = prog.size() + 1;
        put2(JMPZ, 16'h0000);  // not taken
        put2(STOAC, 16'h0064);
        put1(ENDOP, 2'd0);
        prog[fix] = here();
        put2(STOAC, 16'h0065);
        put1(ENDOP, 2'd0);
        // the last pass stores 1 and the pass count equals the start value
        m_mem[16'h0060] = 16'd1;
        m_mem[16'h0061] = loop_count;
        m_mem[16'h0064] = 16'd1;
        m_ac = 16'd1;
        load_program();
        start_and_wait();
        check_results();
    endtask

    initial
    begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        zero_wait  = 1'b1;
        load_we    = 1'b0;
        load_adr   = 16'h0000;
        i_load_dat = 16'h0000;
        d_load_dat = 16'h0000;
        data_rng   = seed;
        data_rng   = next_rand(data_rng);
        loop_count = data_t'(data_rng % 32'd15 + 32'd1);
        for (int i = 0; i < 4; i++)
        begin
            data_rng     = next_rand(data_rng);
            load_vals[i] = data_rng[15:0];
        end
        repeat (5) @(posedge clk);
        test_reset();
        // first without wait states and then with random back-pressure
        for (int pass = 0; pass < 2; pass++)
        begin
            @(posedge clk);
            zero_wait <= (pass == 0);
            test_arithmetic();
            test_loads();
            test_jumps();
        end
        $display("SIMULATION PASSED");
        $finish;
    end

    initial
    begin
        #(longint'(n_runs) * run_cycles * clk_period);
        abort_run("watchdog expired, the processor did not halt in time");
    end

endmodule

// File: dv/tb_wb_memory.sv
`timescale 1ns/10ps

module tb_wb_memory #(
    parameter int depth = 256
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cyc,
    input  logic               stb,
    input  logic               we,
    input  cpu_bus_pkg::addr_t adr,
    input  cpu_bus_pkg::data_t dat_w,
    output cpu_bus_pkg::data_t dat_r,
    output logic               ack,
    input  logic [1:0]         wait_draw,  // wait states offered for the next access
    input  logic               zero_wait,
    input  logic               load_we,
    input  cpu_bus_pkg::addr_t load_adr,
    input  cpu_bus_pkg::data_t load_dat
);

    import cpu_bus_pkg::*;

    localparam int aw = $clog2(depth);

    data_t      mem [depth];
    logic [1:0] wait_left;
    logic       hit;

    // the access completes on this edge
    assign hit = cyc && stb && !ack && (wait_left == 2'd0);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ack       <= 1'b0;
            wait_left <= 2'd0;
        end
        else
        begin
            ack <= hit;  // single-cycle acknowledge
            if (hit)
                wait_left <= zero_wait ? 2'd0 : wait_draw;
            else if (cyc && stb && !ack)
                wait_left <= wait_left - 2'd1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (load_we)
            mem[load_adr[aw-1:0]] <= load_dat;
        else if (hit && we)
            mem[adr[aw-1:0]] <= dat_w;
        if (hit)
            dat_r <= mem[adr[aw-1:0]];
    end

endmodule

// File: design/accum_cpu.sv
`timescale 1ns/10ps

module accum_cpu #(
    parameter cpu_bus_pkg::addr_t reset_pc = '0
) (
    input  logic               clk,
    input  logic               rst_n,
    // instruction memory, read only
    output logic               i_cyc,
    output logic               i_stb,
    output logic               i_we,
    output cpu_bus_pkg::addr_t i_adr,
    output cpu_bus_pkg::data_t i_dat_w,
    input  cpu_bus_pkg::data_t i_dat_r,
    input  logic               i_ack,
    // data memory
    output logic               d_cyc,
    output logic               d_stb,
    output logic               d_we,
    output cpu_bus_pkg::addr_t d_adr,
    output cpu_bus_pkg::data_t d_dat_w,
    input  cpu_bus_pkg::data_t d_dat_r,
    input  logic               d_ack,
    output cpu_bus_pkg::data_t acc,
    output logic               halted
);

    import cpu_bus_pkg::*;
    import cpu_isa_pkg::*;

    logic     fetch_req;
    logic     fetch_done;
    logic     pc_load;
    addr_t    pc_target;
    data_t    fetch_word;
    logic     data_req;
    logic     data_we;
    logic     data_done;
    addr_t    data_addr;
    data_t    data_rdata;
    dp_cmd_t  dp_cmd;
    reg_sel_t reg_sel;
    logic     zero;

    assign i_we    = 1'b0;
    assign i_dat_w = '0;

    fetch_unit #(
        .reset_pc (reset_pc)
    ) fetch_unit_inst (
        .clk,
        .rst_n,
        .fetch_req,
        .pc_load,
        .pc_target,
        .fetch_done,
        .fetch_word,
        .i_cyc,
        .i_stb,
        .i_adr,
        .i_dat_r,
        .i_ack
    );

    sequencer sequencer_inst (
        .clk,
        .rst_n,
        .fetch_done,
        .fetch_word,
        .zero,
        .data_done,
        .fetch_req,
        .pc_load,
        .pc_target,
        .data_req,
        .data_we,
        .data_addr,
        .dp_cmd,
        .reg_sel,
        .halted
    );

    accumulator_datapath accumulator_datapath_inst (
        .clk,
        .rst_n,
        .dp_cmd,
        .reg_sel,
        .load_data (data_rdata),
        .acc,
        .zero
    );

    data_port data_port_inst (
        .clk,
        .rst_n,
        .data_req,
        .data_we,
        .data_addr,
        .acc,
        .data_done,
        .data_rdata,
        .d_cyc,
        .d_stb,
        .d_we,
        .d_adr,
        .d_dat_w,
        .d_dat_r,
        .d_ack
    );

endmodule

// File: design/data_port.sv
`timescale 1ns/10ps

module data_port (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               data_req,
    input  logic               data_we,
    input  cpu_bus_pkg::addr_t data_addr,
    input  cpu_bus_pkg::data_t acc,
    output logic               data_done,
    output cpu_bus_pkg::data_t data_rdata,
    output logic               d_cyc,
    output logic               d_stb,
    output logic               d_we,
    output cpu_bus_pkg::addr_t d_adr,
    output cpu_bus_pkg::data_t d_dat_w,
    input  cpu_bus_pkg::data_t d_dat_r,
    input  logic               d_ack
);

    import cpu_bus_pkg::*;

    logic  busy;
    logic  we_q;
    addr_t adr_q;
    data_t dat_w_q;   // AC as it was when the store was asked for
    logic  ack_seen;

    assign ack_seen = busy & d_ack;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            busy      <= 1'b0;
            we_q      <= 1'b0;
            data_done <= 1'b0;
        end
        else
        begin
            data_done <= ack_seen;
            if (ack_seen)
                busy <= 1'b0;
            else if (data_req && !busy)
            begin
                busy <= 1'b1;
                we_q <= data_we;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (data_req && !busy)
        begin
            adr_q   <= data_addr;
            dat_w_q <= acc;
        end
        if (ack_seen && !we_q)
            data_rdata <= d_dat_r;
    end

    assign d_cyc   = busy;
    assign d_stb   = busy;
    assign d_we    = busy & we_q;
    assign d_adr   = adr_q;
    assign d_dat_w = dat_w_q;

    // direction and store word follow the request for the whole cycle
    a_d_hold: assert property (@(posedge clk) disable iff (!rst_n)
        d_cyc |-> d_we == data_we && (!d_we || d_dat_w == acc));

endmodule

// File: design/accumulator_datapath.sv
`timescale 1ns/10ps

module accumulator_datapath (
    input  logic                  clk,
    input  logic                  rst_n,
    input  cpu_isa_pkg::dp_cmd_t  dp_cmd,
    input  cpu_isa_pkg::reg_sel_t reg_sel,
    input  cpu_bus_pkg::data_t    load_data,
    output cpu_bus_pkg::data_t    acc,
    output logic                  zero
);

    import cpu_bus_pkg::*;
    import cpu_isa_pkg::*;

    data_t                    regs [4];  // R, R1, R2, R3
    data_t                    reg_q;     // second ALU operand
    data_t                    alu_out;
    logic                     acc_we;
    logic [2*$bits(data_t)-1:0] product;

    assign reg_q   = regs[reg_sel];
    assign product = acc * reg_q;  // full product, AC gets the low half

    ////////////////////////////////////////////////////////////////////////////
    // ALU, all results wrap at 16 bits
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        acc_we = 1'b1;
        case (dp_cmd)
            DP_ADD:       alu_out = acc + reg_q;
            DP_SUB:       alu_out = acc - reg_q;
            DP_MUL:       alu_out = product[$bits(data_t)-1:0];
            DP_SHR:       alu_out = acc >> 1;
            DP_SHL:       alu_out = acc << 1;
            DP_CLEAR:     alu_out = '0;
            DP_INC_AC:    alu_out = acc + data_t'(1);
            DP_REG_TO_AC: alu_out = reg_q;
            DP_LOAD_AC:   alu_out = load_data;
            default:
            begin
                alu_out = acc;
                acc_we  = 1'b0;  // register side commands leave AC alone
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            acc <= '0;
        else if (acc_we)
            acc <= alu_out;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 4; i++)
                regs[i] <= '0;
        end
        else if (dp_cmd == DP_AC_TO_REG)
            regs[reg_sel] <= acc;
        else if (dp_cmd == DP_INC_REG)
            regs[reg_sel] <= reg_q + data_t'(1);
    end

    assign zero = (acc == '0);

endmodule

// File: design/sequencer.sv
`timescale 1ns/10ps

module sequencer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  fetch_done,
    input  cpu_bus_pkg::data_t    fetch_word,
    input  logic                  zero,
    input  logic                  data_done,
    output logic                  fetch_req,
    output logic                  pc_load,
    output cpu_bus_pkg::addr_t    pc_target,
    output logic                  data_req,
    output logic                  data_we,
    output cpu_bus_pkg::addr_t    data_addr,
    output cpu_isa_pkg::dp_cmd_t  dp_cmd,
    output cpu_isa_pkg::reg_sel_t reg_sel,
    output logic                  halted
);

    import cpu_bus_pkg::*;
    import cpu_isa_pkg::*;

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        FETCH_OPERAND,
        MEM_ACCESS,
        EXECUTE,
        HALT
    } state_t;

    state_t  state;
    data_t   ir;
    data_t   operand;     // address or jump target
    opcode_t opcode;
    logic    issued;      // request of the current state is out on the bus
    logic    jump_taken;

    function automatic dp_cmd_t dp_cmd_of(input opcode_t op);
        case (op)
            ADD:     return DP_ADD;
            SUB:     return DP_SUB;
            MUL:     return DP_MUL;
            SHR:     return DP_SHR;
            SHL:     return DP_SHL;
            CLAC:    return DP_CLEAR;
            INCAC:   return DP_INC_AC;
            MVAC:    return DP_AC_TO_REG;
            MOVREG:  return DP_REG_TO_AC;
            INCR:    return DP_INC_REG;
            LODAC:   return DP_LOAD_AC;
            default: return DP_NONE;   // unknown codes behave as NOP
        endcase
    endfunction

    assign opcode = opcode_t'(ir[15:8]);

    // zero still reflects the instruction before the jump
    always_comb
    begin
        case (opcode)
            JUMP:    jump_taken = 1'b1;
            JMPZ:    jump_taken = zero;
            JMPNZ:   jump_taken = !zero;
            default: jump_taken = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // execute state machine
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state  <= FETCH;
            issued <= 1'b0;
        end
        else
        begin
            if (fetch_req || data_req)
                issued <= 1'b1;
            case (state)
                FETCH:
                    if (fetch_done)
                    begin
                        issued <= 1'b0;
                        state  <= DECODE;
                    end
                DECODE:
                    if (opcode == ENDOP)
                        state <= HALT;
                    else if (has_operand(opcode))
                        state <= FETCH_OPERAND;
                    else
                        state <= EXECUTE;
                FETCH_OPERAND:
                    if (fetch_done)
                    begin
                        issued <= 1'b0;
                        state  <= (opcode == LODAC || opcode == STOAC) ? MEM_ACCESS : EXECUTE;
                    end
                MEM_ACCESS:
                    if (data_done)
                    begin
                        issued <= 1'b0;
                        state  <= EXECUTE;
                    end
                EXECUTE: state <= FETCH;
                HALT:    state <= HALT;  // left only through reset
                default: state <= FETCH;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == FETCH && fetch_done)
            ir <= fetch_word;
        if (state == FETCH_OPERAND && fetch_done)
            operand <= fetch_word;
    end

    assign fetch_req = (state == FETCH || state == FETCH_OPERAND) && !issued;
    assign data_req  = (state == MEM_ACCESS) && !issued;
    assign data_we   = (opcode == STOAC);
    assign data_addr = operand;
    assign pc_load   = (state == EXECUTE) && jump_taken;
    assign pc_target = operand;
    assign dp_cmd    = (state == EXECUTE) ? dp_cmd_of(opcode) : DP_NONE;
    assign reg_sel   = reg_sel_t'(ir[1:0]);
    assign halted    = (state == HALT);

    // a new request never meets the completion of another access
    a_one_req: assert property (@(posedge clk) disable iff (!rst_n)
        (fetch_req || data_req) |-> !fetch_done && !data_done);

endmodule

// File: design/fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit #(
    parameter cpu_bus_pkg::addr_t reset_pc = '0
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               fetch_req,
    input  logic               pc_load,
    input  cpu_bus_pkg::addr_t pc_target,
    output logic               fetch_done,
    output cpu_bus_pkg::data_t fetch_word,
    output logic               i_cyc,
    output logic               i_stb,
    output cpu_bus_pkg::addr_t i_adr,
    input  cpu_bus_pkg::data_t i_dat_r,
    input  logic               i_ack
);

    import cpu_bus_pkg::*;

    addr_t pc;
    logic  busy;      // read cycle open on the instruction bus
    logic  ack_seen;

    assign ack_seen = busy & i_ack;

    ////////////////////////////////////////////////////////////////////////////
    // bus cycle control
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            busy       <= 1'b0;
            fetch_done <= 1'b0;
        end
        else
        begin
            fetch_done <= ack_seen;  // one pulse per completed read
            if (ack_seen)
                busy <= 1'b0;
            else if (fetch_req && !busy)
                busy <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (ack_seen)
            fetch_word <= i_dat_r;
    end

    // a jump wins over the increment, the sequencer only loads between reads
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            pc <= reset_pc;
        else if (pc_load)
            pc <= pc_target;
        else if (ack_seen)
            pc <= pc + addr_t'(1);
    end

    assign i_cyc = busy;
    assign i_stb = busy;
    assign i_adr = pc;

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    // the strobe and address hold until the slave answers
    a_i_hold: assert property (@(posedge clk) disable iff (!rst_n)
        i_stb && !i_ack |=> i_stb && $stable(i_adr));

endmodule

// File: design/cpu_isa_pkg.sv
package cpu_isa_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // instruction word is opcode in 15:8, register select in 1:0
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [7:0] {
        NOP    = 8'h00,
        ADD    = 8'h01,
        SUB    = 8'h02,
        MUL    = 8'h03,
        SHR    = 8'h04,
        SHL    = 8'h05,
        CLAC   = 8'h06,
        INCAC  = 8'h07,
        MVAC   = 8'h08,
        MOVREG = 8'h09,
        INCR   = 8'h0A,
        LODAC  = 8'h10,  // address in the next word
        STOAC  = 8'h11,
        JUMP   = 8'h12,  // target in the next word
        JMPZ   = 8'h13,
        JMPNZ  = 8'h14,
        ENDOP  = 8'hFF
    } opcode_t;

    typedef logic [1:0] reg_sel_t;  // 0 is R, then R1, R2, R3

    typedef enum logic [3:0] {
        DP_NONE,
        DP_ADD,
        DP_SUB,
        DP_MUL,
        DP_SHR,
        DP_SHL,
        DP_CLEAR,
        DP_INC_AC,
        DP_AC_TO_REG,
        DP_REG_TO_AC,
        DP_INC_REG,
        DP_LOAD_AC
    } dp_cmd_t;

    // instructions that carry a second word
    function automatic logic has_operand(input logic [7:0] op);
        case (op)
            LODAC, STOAC, JUMP, JMPZ, JMPNZ: return 1'b1;
            default:                         return 1'b0;
        endcase
    endfunction

endpackage

// File: design/cpu_bus_pkg.sv
package cpu_bus_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // wishbone classic bus, one address per 16-bit word
    ////////////////////////////////////////////////////////////////////////////

    localparam int addr_w = 16;
    localparam int data_w = 16;

    // word address on either memory port
    typedef logic [addr_w-1:0] addr_t;

    typedef logic [data_w-1:0] data_t;  // bus word, also AC and register width

endpackage
